// ==== tbi_pkg.sv ====
/* Shared TBI and register definitions for the LVDS adaptation layer
   Register map assumes a 2-bit word address on a 32-bit Wishbone port */

package tbi_pkg;

  // --------------------------------------------------
  // TBI code group
  // --------------------------------------------------
  localparam int tbi_width = 10;                 // One 8b/10b code group

  typedef logic [tbi_width-1:0] tbi_code_t;      // Bit 0 is first on the line per Clause 36

  // --------------------------------------------------
  // Wishbone register port
  // --------------------------------------------------
  localparam int wb_addr_width = 2;              // Word address
  localparam int wb_data_width = 32;

  localparam logic [wb_addr_width-1:0] reg_ctrl_addr   = 2'd0;  // Read/write control
  localparam logic [wb_addr_width-1:0] reg_status_addr = 2'd1;  // Live and sticky status
  localparam logic [wb_addr_width-1:0] reg_id_addr     = 2'd2;  // Read-only identifier

  // Fixed identifier so software can find the block
  localparam logic [wb_data_width-1:0] adapter_id = 32'h7B10_0A01;

  // Control register fields
  localparam int ctrl_loopback_bit = 0;          // Reverse loopback enable

  // Status register fields
  localparam int stat_done_bit      = 0;         // Receiver reset sequence complete
  localparam int stat_locked_bit    = 1;         // Live LVDS receiver lock
  localparam int stat_overflow_bit  = 2;         // Sticky, loopback FIFO lost a word
  localparam int stat_underflow_bit = 3;         // Sticky, loopback FIFO ran dry

endpackage

// ==== lvds_rx_reset_sequencer.sv ====
/* Receiver bring-up after lock. rx_locked must be synchronous to ref_clk
   Needs lock_wait_cycles and settle_cycles of at least 1 */

`timescale 1ns/1ps

module lvds_rx_reset_sequencer #(
  parameter int lock_wait_cycles = 16,   // Lock-stable cycles before alignment
  parameter int settle_cycles    = 8     // Cycles after alignment before release
) (
  input  logic ref_clk,
  input  logic reset_ref_clk_int,
  input  logic rx_locked,
  output logic rx_reset,                 // Held high until the sequence is done
  output logic rx_cda_reset,             // One-cycle pulse
  output logic rx_channel_data_align,    // One-cycle pulse after rx_cda_reset
  output logic rx_ready                  // Receive data may be used
);

  // Shared counter must cover the longer of the two waits
  localparam int cnt_max   = (lock_wait_cycles > settle_cycles) ? lock_wait_cycles
                                                                  : settle_cycles;
  localparam int cnt_width = $clog2(cnt_max + 1);

  typedef enum logic [2:0] {
    st_wait_lock,
    st_cda_reset,
    st_align,
    st_settle,
    st_done
  } seq_state_t;

  seq_state_t           state;
  logic [cnt_width-1:0] cnt;             // Lock wait or settle count

  // --------------------------------------------------
  // Sequence FSM
  // --------------------------------------------------
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      state <= st_wait_lock;
      cnt   <= '0;
    end
    else if (!rx_locked)
    begin
      // Lock lost, restart from any state
      state <= st_wait_lock;
      cnt   <= '0;
    end
    else
    begin
      case (state)
        st_wait_lock:
        begin
          if (cnt == cnt_width'(lock_wait_cycles - 1))
          begin
            state <= st_cda_reset;
            cnt   <= '0;
          end
          else
            cnt <= cnt + 1'b1;                 // Consecutive locked cycles
        end
        st_cda_reset: state <= st_align;       // Clear the CDA block first
        st_align:     state <= st_settle;      // Then one align request
        st_settle:
        begin
          if (cnt == cnt_width'(settle_cycles - 1))
          begin
            state <= st_done;
            cnt   <= '0;
          end
          else
            cnt <= cnt + 1'b1;
        end
        default:      state <= st_done;        // Stay done while locked
      endcase
    end
  end

  // Moore outputs, all change one cycle after the sampled event
  assign rx_reset              = (state != st_done);
  assign rx_ready              = (state == st_done);
  assign rx_cda_reset          = (state == st_cda_reset);
  assign rx_channel_data_align = (state == st_align);

endmodule

// ==== tbi_rx_aligner.sv ====
/* Receive bit-order reversal. The deserializer delivers bit 9 first
   Output holds while rx_ready is low */

`timescale 1ns/1ps

module tbi_rx_aligner (
  input  logic              ref_clk,
  input  logic              reset_ref_clk_int,
  input  tbi_pkg::tbi_code_t lvds_rx_word,      // Deserializer word, bit 9 first
  input  logic              rx_ready,          // Receiver reset sequence done
  output tbi_pkg::tbi_code_t tbi_rx_d,          // To PCS, bit 0 first
  output logic              rx_push            // New word on tbi_rx_d
);

  // --------------------------------------------------
  // Reversal register
  // --------------------------------------------------
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      tbi_rx_d <= '0;
      rx_push  <= 1'b0;
    end
    else
    begin
      // Strobe lines up with the word it marks
      rx_push <= rx_ready;

      // Words before alignment are garbage so keep the last good one
      if (rx_ready)
        tbi_rx_d <= {<<{lvds_rx_word}};        // Restore Clause 36 order
    end
  end

endmodule

// ==== tbi_loopback_fifo.sv ====
/* Reverse loopback buffer. No back-pressure, lost words set overflow
   fifo_depth must be a power of two and fifo_prefill no larger than it */

`timescale 1ns/1ps

module tbi_loopback_fifo #(
  parameter int fifo_depth   = 8,        // Entries, power of two
  parameter int fifo_prefill = 4         // Fill level that starts reading
) (
  input  logic               ref_clk,
  input  logic               reset_ref_clk_int,
  input  logic               loopback_ena,     // Low flushes the buffer
  input  logic               push,
  input  tbi_pkg::tbi_code_t push_word,
  output tbi_pkg::tbi_code_t pop_word,         // Zero when nothing was read
  output logic               overflow,         // Sticky
  output logic               underflow,        // Sticky
  input  logic               status_clear      // Clears both sticky flags
);

  localparam int aw = $clog2(fifo_depth);

  tbi_pkg::tbi_code_t mem [fifo_depth];
  logic [aw-1:0]      wr_ptr;
  logic [aw-1:0]      rd_ptr;
  logic [aw:0]        fill;                    // One extra bit to tell full from empty
  logic               running;                 // Prefill reached, pop every cycle
  logic               rd_en;
  logic               rd_ok;
  logic               wr_en;
  logic               wr_ok;
  logic               full;
  logic               empty;

  assign full  = (fill == (aw + 1)'(fifo_depth));
  assign empty = (fill == '0);
  assign wr_en = push && loopback_ena;
  assign rd_en = running && loopback_ena;
  assign rd_ok = rd_en && !empty;
  assign wr_ok = wr_en && (!full || rd_ok);     // A pop in the same cycle frees a slot

  // --------------------------------------------------
  // Storage, no reset
  // --------------------------------------------------
  always_ff @(posedge ref_clk)
  begin
    if (wr_ok)
      mem[wr_ptr] <= push_word;
  end

  // --------------------------------------------------
  // Pointers, fill, prefill latch and flags
  // --------------------------------------------------
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      fill      <= '0;
      running   <= 1'b0;
      pop_word  <= '0;
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end
    else
    begin
      if (!loopback_ena)
      begin
        // Flush
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        fill     <= '0;
        running  <= 1'b0;
        pop_word <= '0;
      end
      else
      begin
        if (wr_ok)
          wr_ptr <= wr_ptr + 1'b1;
        if (rd_ok)
          rd_ptr <= rd_ptr + 1'b1;
        fill     <= fill + (aw + 1)'(wr_ok) - (aw + 1)'(rd_ok);
        pop_word <= rd_ok ? mem[rd_ptr] : '0;   // Empty pop gives zero
        if (fill >= (aw + 1)'(fifo_prefill))
          running <= 1'b1;                     // Latched until flush
      end

      // Sticky flags, a new event wins over a clear
      if (wr_en && !wr_ok)
        overflow <= 1'b1;
      else if (status_clear)
        overflow <= 1'b0;

      if (rd_en && empty)
        underflow <= 1'b1;
      else if (status_clear)
        underflow <= 1'b0;
    end
  end

endmodule

// ==== tbi_tx_reorder.sv ====
/* Transmit source select and bit-order reversal for the serializer
   Serializer sends bit 9 first so the PCS word is reversed here */

`timescale 1ns/1ps

module tbi_tx_reorder (
  input  logic               ref_clk,
  input  logic               reset_ref_clk_int,
  input  logic               loopback_ena,     // Select loopback word
  input  tbi_pkg::tbi_code_t tbi_tx_d,         // From PCS, bit 0 first
  input  tbi_pkg::tbi_code_t loop_word,        // From loopback FIFO
  output tbi_pkg::tbi_code_t tx_word           // To serializer, bit 9 first
);

  tbi_pkg::tbi_code_t tx_sel;

  // --------------------------------------------------
  // Source select
  // --------------------------------------------------
  // Loopback words were already reversed once by the receive path,
  // the second reversal here puts them back in line order
  assign tx_sel = loopback_ena ? loop_word : tbi_tx_d;

  // --------------------------------------------------
  // Reversal register
  // --------------------------------------------------
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
      tx_word <= '0;
    else
      tx_word <= {<<{tx_sel}};                 // Bit 0 goes to bit 9
  end

endmodule

// ==== pma_ctrl_regs.sv ====
/* Wishbone classic slave with single-cycle ack and no wait states
   Writing a one to either sticky bit of status clears both flags */

`timescale 1ns/1ps

module pma_ctrl_regs (
  input  logic                                ref_clk,
  input  logic                                reset_ref_clk_int,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [tbi_pkg::wb_addr_width-1:0]   wb_adr,
  input  logic [tbi_pkg::wb_data_width-1:0]   wb_dat_w,
  output logic [tbi_pkg::wb_data_width-1:0]   wb_dat_r,
  output logic                                wb_ack,
  input  logic                                rx_ready,     // Live, sequence done
  input  logic                                rx_locked,    // Live lock
  input  logic                                overflow,     // Sticky from FIFO
  input  logic                                underflow,    // Sticky from FIFO
  output logic                                loopback_ena,
  output logic                                status_clear  // One-cycle pulse
);

  logic [tbi_pkg::wb_data_width-1:0] ctrl_q;     // Control register
  logic [tbi_pkg::wb_data_width-1:0] status_w;   // Assembled status word
  logic [tbi_pkg::wb_data_width-1:0] rd_data;
  logic                              acc;        // New access this cycle
  logic                              wr_acc;

  // Ignore the cycle that already carries ack, the master drops stb then
  assign acc    = wb_cyc && wb_stb && !wb_ack;
  assign wr_acc = acc && wb_we;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb
  begin
    status_w                              = '0;
    status_w[tbi_pkg::stat_done_bit]      = rx_ready;
    status_w[tbi_pkg::stat_locked_bit]    = rx_locked;
    status_w[tbi_pkg::stat_overflow_bit]  = overflow;
    status_w[tbi_pkg::stat_underflow_bit] = underflow;

    case (wb_adr)
      tbi_pkg::reg_ctrl_addr:   rd_data = ctrl_q;
      tbi_pkg::reg_status_addr: rd_data = status_w;
      tbi_pkg::reg_id_addr:     rd_data = tbi_pkg::adapter_id;
      default:                  rd_data = '0;   // Unmapped
    endcase
  end

  // --------------------------------------------------
  // Ack, write and read data
  // --------------------------------------------------
  always_ff @(posedge ref_clk or posedge reset_ref_clk_int)
  begin
    if (reset_ref_clk_int)
    begin
      wb_ack       <= 1'b0;
      wb_dat_r     <= '0;
      ctrl_q       <= '0;                        // Loopback off
      status_clear <= 1'b0;
    end
    else
    begin
      wb_ack       <= acc;                       // Exactly one cycle per access
      status_clear <= 1'b0;
      if (acc)
        wb_dat_r <= rd_data;                     // Valid in the ack cycle
      if (wr_acc && (wb_adr == tbi_pkg::reg_ctrl_addr))
        ctrl_q <= wb_dat_w;
      if (wr_acc && (wb_adr == tbi_pkg::reg_status_addr))
        status_clear <= wb_dat_w[tbi_pkg::stat_overflow_bit] ||
                        wb_dat_w[tbi_pkg::stat_underflow_bit];
    end
  end

  assign loopback_ena = ctrl_q[tbi_pkg::ctrl_loopback_bit];

endmodule

// ==== tbi_pma_adapter.sv ====
/* LVDS adaptation layer between a GbE PCS and a parallel SERDES
   Single clock. The recovered receive clock is assumed equal to ref_clk
   and reset_ref_clk_int must already be synchronized to it */

`timescale 1ns/1ps

module tbi_pma_adapter #(
  parameter int lock_wait_cycles = 16,
  parameter int settle_cycles    = 8,
  parameter int fifo_depth       = 8,
  parameter int fifo_prefill     = 4
) (
  input  logic                              ref_clk,
  input  logic                              reset_ref_clk_int,
  // Host register port
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [tbi_pkg::wb_addr_width-1:0] wb_adr,
  input  logic [tbi_pkg::wb_data_width-1:0] wb_dat_w,
  output logic [tbi_pkg::wb_data_width-1:0] wb_dat_r,
  output logic                              wb_ack,
  // SERDES side
  input  tbi_pkg::tbi_code_t                lvds_rx_word,
  input  logic                              rx_locked,
  output logic                              rx_cda_reset,
  output logic                              rx_channel_data_align,
  output tbi_pkg::tbi_code_t                tx_word,
  // PCS side
  input  tbi_pkg::tbi_code_t                tbi_tx_d,
  output tbi_pkg::tbi_code_t                tbi_rx_d,
  output logic                              rx_reset,
  output logic                              rx_ready
);

  logic               rx_push;        // Receive word strobe
  logic               loopback_ena;
  logic               overflow;
  logic               underflow;
  logic               status_clear;
  tbi_pkg::tbi_code_t loop_word;      // FIFO to transmit stage

  // --------------------------------------------------
  // Receive path
  // --------------------------------------------------
  lvds_rx_reset_sequencer #(
    .lock_wait_cycles (lock_wait_cycles),
    .settle_cycles    (settle_cycles)
  ) u_seq (
    .ref_clk               (ref_clk),
    .reset_ref_clk_int     (reset_ref_clk_int),
    .rx_locked             (rx_locked),
    .rx_reset              (rx_reset),
    .rx_cda_reset          (rx_cda_reset),
    .rx_channel_data_align (rx_channel_data_align),
    .rx_ready              (rx_ready)
  );

  tbi_rx_aligner u_rx (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .lvds_rx_word      (lvds_rx_word),
    .rx_ready          (rx_ready),
    .tbi_rx_d          (tbi_rx_d),
    .rx_push           (rx_push)
  );

  // --------------------------------------------------
  // Reverse loopback and transmit path
  // --------------------------------------------------
  tbi_loopback_fifo #(
    .fifo_depth   (fifo_depth),
    .fifo_prefill (fifo_prefill)
  ) u_fifo (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .loopback_ena      (loopback_ena),
    .push              (rx_push),
    .push_word         (tbi_rx_d),
    .pop_word          (loop_word),
    .overflow          (overflow),
    .underflow         (underflow),
    .status_clear      (status_clear)
  );

  tbi_tx_reorder u_tx (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .loopback_ena      (loopback_ena),
    .tbi_tx_d          (tbi_tx_d),
    .loop_word         (loop_word),
    .tx_word           (tx_word)
  );

  // Control and status
  pma_ctrl_regs u_regs (
    .ref_clk           (ref_clk),
    .reset_ref_clk_int (reset_ref_clk_int),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_dat_w          (wb_dat_w),
    .wb_dat_r          (wb_dat_r),
    .wb_ack            (wb_ack),
    .rx_ready          (rx_ready),
    .rx_locked         (rx_locked),
    .overflow          (overflow),
    .underflow         (underflow),
    .loopback_ena      (loopback_ena),
    .status_clear      (status_clear)
  );

endmodule

// ==== tb_tbi_pma_adapter.sv ====
/* Directed testbench for the TBI adaptation layer. Inputs change 1 ns after
   the rising edge and outputs are sampled there, after all registers settle */

`timescale 1ns/1ps

module tb_tbi_pma_adapter;

  localparam int lock_wait_cycles = 8;
  localparam int settle_cycles    = 4;
  localparam int fifo_depth       = 8;
  localparam int fifo_prefill     = 4;
  localparam int loop_words       = 32;          // Words sent through loopback
  localparam int test_count       = 6;
  localparam int seq_limit        = lock_wait_cycles + settle_cycles + 10;
  localparam int ack_limit        = 8;
  // Every test may run twice its worst length
  localparam int watchdog_cycles  = 20 + test_count * 2 *
    (lock_wait_cycles + settle_cycles + fifo_prefill + fifo_depth + loop_words + 40);

  logic                              ref_clk;
  logic                              reset_ref_clk_int;
  logic                              wb_cyc;
  logic                              wb_stb;
  logic                              wb_we;
  logic [tbi_pkg::wb_addr_width-1:0] wb_adr;
  logic [tbi_pkg::wb_data_width-1:0] wb_dat_w;
  logic [tbi_pkg::wb_data_width-1:0] wb_dat_r;
  logic                              wb_ack;
  tbi_pkg::tbi_code_t                lvds_rx_word;
  logic                              rx_locked;
  logic                              rx_cda_reset;
  logic                              rx_channel_data_align;
  tbi_pkg::tbi_code_t                tx_word;
  tbi_pkg::tbi_code_t                tbi_tx_d;
  tbi_pkg::tbi_code_t                tbi_rx_d;
  logic                              rx_reset;
  logic                              rx_ready;
  int                                errors;
  int                                checks;

  tbi_pma_adapter #(
    .lock_wait_cycles (lock_wait_cycles),
    .settle_cycles    (settle_cycles),
    .fifo_depth       (fifo_depth),
    .fifo_prefill     (fifo_prefill)
  ) dut (
    .ref_clk               (ref_clk),
    .reset_ref_clk_int     (reset_ref_clk_int),
    .wb_cyc                (wb_cyc),
    .wb_stb                (wb_stb),
    .wb_we                 (wb_we),
    .wb_adr                (wb_adr),
    .wb_dat_w              (wb_dat_w),
    .wb_dat_r              (wb_dat_r),
    .wb_ack                (wb_ack),
    .lvds_rx_word          (lvds_rx_word),
    .rx_locked             (rx_locked),
    .rx_cda_reset          (rx_cda_reset),
    .rx_channel_data_align (rx_channel_data_align),
    .tx_word               (tx_word),
    .tbi_tx_d              (tbi_tx_d),
    .tbi_rx_d              (tbi_rx_d),
    .rx_reset              (rx_reset),
    .rx_ready              (rx_ready)
  );

  initial
  begin
    ref_clk = 1'b0;
    forever #2 ref_clk = ~ref_clk;               // 4 ns period
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic step;                           // To 1 ns after the next edge
    @(posedge ref_clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Line order is bit 9 first and PCS order bit 0 first
  function automatic tbi_pkg::tbi_code_t reverse_bits(input tbi_pkg::tbi_code_t w);
    tbi_pkg::tbi_code_t r;
    for (int i = 0; i < tbi_pkg::tbi_width; i++)
      r[i] = w[tbi_pkg::tbi_width-1-i];
    return r;
  endfunction

  function automatic tbi_pkg::tbi_code_t random_nonzero_word();
    tbi_pkg::tbi_code_t w;
    w = tbi_pkg::tbi_code_t'($urandom);
    if (w == '0)
      w = 10'h001;                               // Zero marks idle in loopback
    return w;
  endfunction

  // One Wishbone classic access with stb dropped in the ack cycle
  task automatic wb_access(input logic we, input logic [tbi_pkg::wb_addr_width-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles   = 0;
    rdata    = '0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    do
    begin
      step();
      cycles++;
    end
    while (!wb_ack && cycles < ack_limit);
    if (!wb_ack)
      report_failure("no wb_ack for a register access");
    else
    begin
      check_value("wb_ack latency", 32'(cycles), 32'd1);
      rdata = wb_dat_r;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    step();
    check_value("wb_ack after ack cycle", 32'(wb_ack), 32'd0);   // Single-cycle ack
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  // Lock must be raised by the caller in the current cycle
  task automatic test_reset_sequence;
    int cycles;
    int cda_count;
    int align_count;
    logic cda_prev;
    cycles      = 0;
    cda_count   = 0;
    align_count = 0;
    cda_prev    = 1'b0;
    while (!rx_ready && cycles < seq_limit)
    begin
      step();
      cycles++;
      if (rx_cda_reset)
        cda_count++;
      if (rx_channel_data_align)
      begin
        align_count++;
        if (!cda_prev)
          report_failure("rx_channel_data_align did not follow rx_cda_reset");
      end
      cda_prev = rx_cda_reset;
    end
    if (!rx_ready)
      report_failure("rx_ready did not rise after lock");
    check_value("rx_cda_reset pulses", 32'(cda_count), 32'd1);
    check_value("rx_channel_data_align pulses", 32'(align_count), 32'd1);
    check_value("rx_ready cycle", 32'(cycles), 32'(lock_wait_cycles + settle_cycles + 2));
    check_value("rx_reset when ready", 32'(rx_reset), 32'd0);
  endtask

  task automatic test_rx_reversal;
    tbi_pkg::tbi_code_t word;
    for (int i = 0; i < 20; i++)
    begin
      word         = tbi_pkg::tbi_code_t'($urandom);
      lvds_rx_word = word;
      step();
      check_value("tbi_rx_d", 32'(tbi_rx_d), 32'(reverse_bits(word)));
    end
  endtask

  task automatic test_tx_reversal;
    tbi_pkg::tbi_code_t word;
    for (int i = 0; i < 20; i++)
    begin
      word     = tbi_pkg::tbi_code_t'($urandom);
      tbi_tx_d = word;
      step();
      check_value("tx_word", 32'(tx_word), 32'(reverse_bits(word)));
    end
  endtask

  task automatic test_registers;
    logic [31:0] rdata;
    wb_access(1'b1, tbi_pkg::reg_ctrl_addr, 32'hA5A5_5A5A, rdata);  // Loopback bit clear
    wb_access(1'b0, tbi_pkg::reg_ctrl_addr, 32'h0, rdata);
    check_value("ctrl readback", rdata, 32'hA5A5_5A5A);
    wb_access(1'b1, tbi_pkg::reg_ctrl_addr, 32'h0, rdata);
    wb_access(1'b0, tbi_pkg::reg_id_addr, 32'h0, rdata);
    check_value("id register", rdata, tbi_pkg::adapter_id);
    wb_access(1'b0, tbi_pkg::reg_status_addr, 32'h0, rdata);
    check_value("status done", 32'(rdata[tbi_pkg::stat_done_bit]), 32'd1);
    check_value("status locked", 32'(rdata[tbi_pkg::stat_locked_bit]), 32'd1);
  endtask

  task automatic test_loopback;
    tbi_pkg::tbi_code_t sent [$];
    logic [31:0]        rdata;
    int                 idx;
    logic               started;
    idx          = 0;
    started      = 1'b0;
    lvds_rx_word = '0;                           // Idle zeros fill the FIFO first
    tbi_tx_d     = '0;
    wb_access(1'b1, tbi_pkg::reg_ctrl_addr, 32'h1, rdata);
    repeat (fifo_depth + 4) step();
    for (int i = 0; i < loop_words + fifo_depth + 8; i++)
    begin
      if (tx_word != '0)
        started = 1'b1;
      if (started && idx < loop_words)
      begin
        check_value("loopback tx_word", 32'(tx_word), 32'(sent[idx]));
        idx++;
      end
      if (i < loop_words)
      begin
        sent.push_back(random_nonzero_word());
        lvds_rx_word = sent[i];
      end
      else
        lvds_rx_word = '0;
      step();
    end
    if (idx != loop_words)
      report_failure($sformatf("loopback returned %0d of %0d words", idx, loop_words));
    wb_access(1'b0, tbi_pkg::reg_status_addr, 32'h0, rdata);
    check_value("status overflow", 32'(rdata[tbi_pkg::stat_overflow_bit]), 32'd0);
    check_value("status underflow", 32'(rdata[tbi_pkg::stat_underflow_bit]), 32'd0);
    wb_access(1'b1, tbi_pkg::reg_ctrl_addr, 32'h0, rdata);
  endtask

  task automatic test_lock_loss;
    rx_locked = 1'b0;
    step();
    check_value("rx_ready after lock loss", 32'(rx_ready), 32'd0);
    check_value("rx_reset after lock loss", 32'(rx_reset), 32'd1);
    rx_locked = 1'b1;
    test_reset_sequence();
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial
  begin
    errors            = 0;
    checks            = 0;
    void'($urandom(72395));                      // Fixed seed for repeatable stimulus
    reset_ref_clk_int = 1'b1;
    wb_cyc            = 1'b0;
    wb_stb            = 1'b0;
    wb_we             = 1'b0;
    wb_adr            = '0;
    wb_dat_w          = '0;
    lvds_rx_word      = '0;
    rx_locked         = 1'b0;
    tbi_tx_d          = '0;
    repeat (10) @(posedge ref_clk);
    #1;
    reset_ref_clk_int = 1'b0;
    check_value("rx_ready after reset", 32'(rx_ready), 32'd0);
    check_value("rx_reset after reset", 32'(rx_reset), 32'd1);
    check_value("rx_cda_reset after reset", 32'(rx_cda_reset), 32'd0);
    check_value("rx_channel_data_align after reset", 32'(rx_channel_data_align), 32'd0);
    check_value("wb_ack after reset", 32'(wb_ack), 32'd0);
    check_value("tx_word after reset", 32'(tx_word), 32'd0);
    rx_locked = 1'b1;
    test_reset_sequence();
    test_rx_reversal();
    test_tx_reversal();
    test_registers();
    test_loopback();
    test_lock_loss();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge ref_clk);
    $display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== src.f ====
tbi_pkg.sv
lvds_rx_reset_sequencer.sv
tbi_rx_aligner.sv
tbi_loopback_fifo.sv
tbi_tx_reorder.sv
pma_ctrl_regs.sv
tbi_pma_adapter.sv
tb_tbi_pma_adapter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, run from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_tbi_pma_adapter -f src.f \
  --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation run returned status $run_status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
exit 0
